// ==== opl3_mix_defines.svh ====
/*
 * Widths and counts shared by the channel mixing stage.
 * Include wherever a port or a type is sized from these values.
 */
`ifndef OPL3_MIX_DEFINES_SVH
`define OPL3_MIX_DEFINES_SVH

// word widths
`define OP_OUT_WIDTH      13  // one operator output
`define CHAN_WIDTH        15  // sum of up to three operators
`define ACC_WIDTH         30  // bus accumulator
`define SAMPLE_WIDTH      15  // clamped output sample

// array sizes
`define NUM_BANKS         2
`define CHANNELS_PER_BANK 9
`define OPS_PER_BANK      18
`define NUM_OUTPUTS       4   // buses a to d
`define NUM_4OP           3   // 4-op capable channels per bank

`endif

// ==== opl3_mix_pkg.sv ====
/*
 * Word types of the channel mixing stage.
 * Modules take these by a wildcard import in their header.
 */
`include "opl3_mix_defines.svh"

package opl3_mix_pkg;

    typedef logic signed [`OP_OUT_WIDTH-1:0] op_word_t;
    typedef logic signed [`CHAN_WIDTH-1:0]   chan_word_t;
    typedef logic signed [`ACC_WIDTH-1:0]    acc_t;
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // slot address used during the sweep
    typedef struct packed {
        logic       bank;
        logic [3:0] chan;
    } slot_t;

endpackage

// ==== mix_seq_if.sv ====
/*
 * Sweep control from the sequencer to the capture, connection and mixer blocks.
 */
`timescale 1ns/1ps

interface mix_seq_if
    import opl3_mix_pkg::*;
;
    logic  start;       // sweep begins, inputs are frozen
    logic  slot_valid;  // slot carries a channel this cycle
    slot_t slot;
    logic  clear;       // empties the accumulators
    logic  latch;       // sweep result complete

    modport seq (
        output start,
        output slot_valid,
        output slot,
        output clear,
        output latch
    );

    modport cap  (input start);
    modport conn (input slot_valid, input slot);
    modport mix  (input clear, input latch);

endinterface

// ==== op_capture.sv ====
/*
 * Freezes the operator outputs and connection controls at the start of a sweep,
 * so the whole sweep works on one consistent frame.
 */
`timescale 1ns/1ps
`include "opl3_mix_defines.svh"

module op_capture
    import opl3_mix_pkg::*;
(
    input  logic                                               clk,
    input  logic                                               rst_n,
    mix_seq_if.cap                                             seq,
    input  op_word_t [`NUM_BANKS*`OPS_PER_BANK-1:0]            op_out,
    input  logic [`NUM_BANKS*`CHANNELS_PER_BANK-1:0]           cnt,
    input  logic [`NUM_BANKS*`NUM_4OP-1:0]                     connection_sel,
    input  logic                                               ryt,
    input  logic [`NUM_OUTPUTS-1:0][`NUM_BANKS*`CHANNELS_PER_BANK-1:0] out_en,
    output op_word_t [`NUM_BANKS*`OPS_PER_BANK-1:0]            op_hold,
    output logic [`NUM_BANKS*`CHANNELS_PER_BANK-1:0]           cnt_hold,
    output logic [`NUM_BANKS*`NUM_4OP-1:0]                     sel_hold,
    output logic                                               ryt_hold,
    output logic [`NUM_OUTPUTS-1:0][`NUM_BANKS*`CHANNELS_PER_BANK-1:0] en_hold
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_hold <= '0;
            sel_hold <= '0;
            ryt_hold <= 1'b0;
            en_hold  <= '0;  // no bus enabled
        end else if (seq.start) begin
            cnt_hold <= cnt;
            sel_hold <= connection_sel;
            ryt_hold <= ryt;
            en_hold  <= out_en;
        end
    end

    always_ff @(posedge clk) begin
        if (seq.start) begin
            op_hold <= op_out;
        end
    end

endmodule

// ==== mix_sequencer.sv ====
/*
 * Idle/sweep FSM. A strobe in idle starts a sweep over the 18 channel slots,
 * followed by one latch cycle before the next strobe can be taken.
 */
`timescale 1ns/1ps
`include "opl3_mix_defines.svh"

module mix_sequencer
    import opl3_mix_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   sample_clk_en,
    mix_seq_if.seq seq
);

    localparam int NUM_SLOTS = `NUM_BANKS * `CHANNELS_PER_BANK;

    typedef enum logic {
        IDLE,
        SWEEP
    } state_t;

    state_t     state;
    logic [4:0] step;       // 0..17 slots, 18 is the latch cycle
    logic       last_step;
    slot_t      slot_addr;

    assign last_step = (step == 5'(NUM_SLOTS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (sample_clk_en) begin
                        state <= SWEEP;
                    end
                end
                SWEEP: begin
                    if (last_step) begin
                        state <= IDLE;
                        step  <= '0;  // idle slot stays in range
                    end else begin
                        step <= step + 5'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // bank 0 channels 0-8 first, then bank 1
    always_comb begin
        slot_addr.bank = (step >= 5'(`CHANNELS_PER_BANK));
        if (slot_addr.bank) begin
            slot_addr.chan = 4'(step - 5'(`CHANNELS_PER_BANK));
        end else begin
            slot_addr.chan = step[3:0];
        end
    end

    assign seq.start      = (state == IDLE) && sample_clk_en;
    assign seq.clear      = seq.start;
    assign seq.slot_valid = (state == SWEEP) && !last_step;
    assign seq.slot       = slot_addr;
    assign seq.latch      = (state == SWEEP) && last_step;

endmodule

// ==== channel_connect.sv ====
/*
 * Forms the channel value of the addressed slot from the frozen operators,
 * with 2-op, 4-op and bank-0 rhythm connections, then gates it into each bus.
 */
`timescale 1ns/1ps
`include "opl3_mix_defines.svh"

module channel_connect
    import opl3_mix_pkg::*;
(
    input  logic                                               clk,
    input  logic                                               rst_n,
    mix_seq_if.conn                                            seq,
    input  op_word_t [`NUM_BANKS*`OPS_PER_BANK-1:0]            op_hold,
    input  logic [`NUM_BANKS*`CHANNELS_PER_BANK-1:0]           cnt_hold,
    input  logic [`NUM_BANKS*`NUM_4OP-1:0]                     sel_hold,
    input  logic                                               ryt_hold,
    input  logic [`NUM_OUTPUTS-1:0][`NUM_BANKS*`CHANNELS_PER_BANK-1:0] en_hold,
    output chan_word_t [`NUM_OUTPUTS-1:0]                      bus_word,
    output logic                                               word_valid
);

    op_word_t   op [`OPS_PER_BANK];  // operators of the addressed bank
    chan_word_t quad_op [4];         // 4-op chain from first to last
    logic [3:0] chan;
    logic [4:0] cnt_base;
    logic [4:0] chan_idx;            // channel index over both banks
    logic [4:0] mod_idx;
    logic [4:0] car_idx;
    logic [1:0] quad;
    logic       cnt_bit;
    logic       use_4op;
    logic       rhythm;
    chan_word_t mod_w;
    chan_word_t car_w;
    chan_word_t two_op;
    chan_word_t four_op;
    chan_word_t rhythm_op;
    chan_word_t chan_val;

    assign chan     = seq.slot.chan;
    assign cnt_base = seq.slot.bank ? 5'(`CHANNELS_PER_BANK) : 5'd0;
    assign chan_idx = cnt_base + 5'(chan);
    assign cnt_bit  = cnt_hold[chan_idx];

    always_comb begin
        for (int i = 0; i < `OPS_PER_BANK; i++) begin
            op[i] = op_hold[seq.slot.bank * `OPS_PER_BANK + i];
        end
    end

    // carrier sits three slots above the modulator
    always_comb begin
        if (chan < 4'd3) begin
            mod_idx = 5'(chan);
        end else if (chan < 4'd6) begin
            mod_idx = 5'(chan) + 5'd3;
        end else begin
            mod_idx = 5'(chan) + 5'd6;
        end
    end

    assign car_idx = mod_idx + 5'd3;
    assign mod_w   = chan_word_t'(op[mod_idx]);
    assign car_w   = chan_word_t'(op[car_idx]);
    assign two_op  = cnt_bit ? mod_w + car_w : car_w;  // additive or FM

    assign quad    = (chan < 4'(`NUM_4OP)) ? chan[1:0] : 2'd0;
    assign use_4op = (chan < 4'(`NUM_4OP)) && sel_hold[seq.slot.bank * `NUM_4OP + quad];

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            quad_op[j] = chan_word_t'(op[quad + 3 * j]);
        end
        case ({cnt_hold[cnt_base + quad], cnt_hold[cnt_base + quad + 3]})
            2'b00:   four_op = quad_op[3];
            2'b01:   four_op = quad_op[1] + quad_op[3];
            2'b10:   four_op = quad_op[0] + quad_op[3];
            default: four_op = quad_op[0] + quad_op[2] + quad_op[3];
        endcase
    end

    // drums only live in bank 0 channels 6-8
    assign rhythm = ryt_hold && !seq.slot.bank && (chan >= 4'd6);

    always_comb begin
        if (chan == 4'd6) begin
            rhythm_op = cnt_bit ? car_w : mod_w;  // bass drum
        end else begin
            rhythm_op = mod_w + car_w;  // hh/sd and tom/tc pairs
        end
    end

    always_comb begin
        if (rhythm) begin
            chan_val = rhythm_op;
        end else if (use_4op) begin
            chan_val = four_op;
        end else begin
            chan_val = two_op;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= seq.slot_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `NUM_OUTPUTS; k++) begin
            bus_word[k] <= en_hold[k][chan_idx] ? chan_val : '0;
        end
    end

endmodule

// ==== output_mixer.sv ====
/*
 * Four bus accumulators. Cleared at sweep start, summed per slot word,
 * then clamped to a 15-bit signed sample one cycle after the latch.
 */
`timescale 1ns/1ps
`include "opl3_mix_defines.svh"

module output_mixer
    import opl3_mix_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    mix_seq_if.mix                        seq,
    input  chan_word_t [`NUM_OUTPUTS-1:0] bus_word,
    input  logic                          word_valid,
    output sample_t                       channel_a,
    output sample_t                       channel_b,
    output sample_t                       channel_c,
    output sample_t                       channel_d,
    output logic                          mix_done
);

    localparam acc_t SAT_MAX = acc_t'(2 ** (`SAMPLE_WIDTH - 1) - 1);
    localparam acc_t SAT_MIN = acc_t'(-(2 ** (`SAMPLE_WIDTH - 1)));

    acc_t acc [`NUM_OUTPUTS];
    logic latch_q;  // last word has landed in acc

    function automatic sample_t clamp(input acc_t value);
        if (value > SAT_MAX) begin
            return sample_t'(SAT_MAX);
        end else if (value < SAT_MIN) begin
            return sample_t'(SAT_MIN);
        end
        return sample_t'(value);
    endfunction

    always_ff @(posedge clk) begin
        for (int k = 0; k < `NUM_OUTPUTS; k++) begin
            if (seq.clear) begin
                acc[k] <= '0;
            end else if (word_valid) begin
                acc[k] <= acc[k] + acc_t'(bus_word[k]);  // sign extended
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            latch_q   <= 1'b0;
            mix_done  <= 1'b0;
            channel_a <= '0;
            channel_b <= '0;
            channel_c <= '0;
            channel_d <= '0;
        end else begin
            latch_q  <= seq.latch;
            mix_done <= latch_q;
            if (latch_q) begin
                channel_a <= clamp(acc[0]);
                channel_b <= clamp(acc[1]);
                channel_c <= clamp(acc[2]);
                channel_d <= clamp(acc[3]);
            end
        end
    end

endmodule

// ==== opl3_mix_top.sv ====
/*
 * Channel mixing stage of the FM core. Operator outputs and connection
 * controls come in as plain ports, the four bus samples leave with mix_done.
 */
`timescale 1ns/1ps
`include "opl3_mix_defines.svh"

module opl3_mix_top
    import opl3_mix_pkg::*;
(
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               sample_clk_en,
    input  op_word_t [`NUM_BANKS*`OPS_PER_BANK-1:0]            op_out,  // bank 1 high
    input  logic [`NUM_BANKS*`CHANNELS_PER_BANK-1:0]           cnt,
    input  logic [`NUM_BANKS*`NUM_4OP-1:0]                     connection_sel,
    input  logic                                               ryt,
    input  logic [`NUM_OUTPUTS-1:0][`NUM_BANKS*`CHANNELS_PER_BANK-1:0] out_en,
    output sample_t                                            channel_a,
    output sample_t                                            channel_b,
    output sample_t                                            channel_c,
    output sample_t                                            channel_d,
    output logic                                               mix_done
);

    op_word_t [`NUM_BANKS*`OPS_PER_BANK-1:0]                  op_hold;
    logic [`NUM_BANKS*`CHANNELS_PER_BANK-1:0]                 cnt_hold;
    logic [`NUM_BANKS*`NUM_4OP-1:0]                           sel_hold;
    logic                                                     ryt_hold;
    logic [`NUM_OUTPUTS-1:0][`NUM_BANKS*`CHANNELS_PER_BANK-1:0] en_hold;
    chan_word_t [`NUM_OUTPUTS-1:0]                            bus_word;
    logic                                                     word_valid;

    mix_seq_if seq_bus ();

    mix_sequencer u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .seq           (seq_bus.seq)
    );

    op_capture u_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .seq            (seq_bus.cap),
        .op_out         (op_out),
        .cnt            (cnt),
        .connection_sel (connection_sel),
        .ryt            (ryt),
        .out_en         (out_en),
        .op_hold        (op_hold),
        .cnt_hold       (cnt_hold),
        .sel_hold       (sel_hold),
        .ryt_hold       (ryt_hold),
        .en_hold        (en_hold)
    );

    channel_connect u_connect (
        .clk        (clk),
        .rst_n      (rst_n),
        .seq        (seq_bus.conn),
        .op_hold    (op_hold),
        .cnt_hold   (cnt_hold),
        .sel_hold   (sel_hold),
        .ryt_hold   (ryt_hold),
        .en_hold    (en_hold),
        .bus_word   (bus_word),
        .word_valid (word_valid)
    );

    output_mixer u_mixer (
        .clk        (clk),
        .rst_n      (rst_n),
        .seq        (seq_bus.mix),
        .bus_word   (bus_word),
        .word_valid (word_valid),
        .channel_a  (channel_a),
        .channel_b  (channel_b),
        .channel_c  (channel_c),
        .channel_d  (channel_d),
        .mix_done   (mix_done)
    );

endmodule

// ==== tb_opl3_mix.sv ====
/*
 * Self-checking testbench for the channel mixing stage. Rows of a stimulus
 * table are strobed into the DUT one by one and each bus is compared against
 * a table value or a connection-rule model computed here.
 */
`timescale 1ns/1ps
`include "opl3_mix_defines.svh"

module tb_opl3_mix
    import opl3_mix_pkg::*;
;
    localparam int NUM_OPS     = `NUM_BANKS * `OPS_PER_BANK;
    localparam int NUM_CH      = `NUM_BANKS * `CHANNELS_PER_BANK;
    localparam int LATENCY     = 20;  // edges from strobe to mix_done
    localparam int WAIT_LIMIT  = 40;
    localparam logic [1:0] FILL_RAND  = 2'd0;  // full 13-bit range
    localparam logic [1:0] FILL_SMALL = 2'd1;  // about +-511, avoids clamping
    localparam logic [1:0] FILL_CONST = 2'd2;
    localparam logic [71:0] EN_ALL    = {4{18'h3ffff}};

    typedef struct packed {
        logic [17:0]      cnt;
        logic [5:0]       sel;
        logic             ryt;
        logic [3:0][17:0] en;
        logic [1:0]       fill;
        op_word_t         fill_val;
        logic             directed;  // exp holds the expected buses
        logic             extra;     // second strobe during the sweep
        sample_t [3:0]    exp;
    } row_t;

    logic                      clk;
    logic                      rst_n;
    logic                      sample_clk_en;
    op_word_t [NUM_OPS-1:0]    op_out;
    logic [NUM_CH-1:0]         cnt;
    logic [5:0]                connection_sel;
    logic                      ryt;
    logic [3:0][NUM_CH-1:0]    out_en;
    sample_t                   channel_a;
    sample_t                   channel_b;
    sample_t                   channel_c;
    sample_t                   channel_d;
    logic                      mix_done;

    op_word_t [NUM_OPS-1:0]    ops;  // frame the model works on
    row_t                      table_q [$];
    integer                    seed = 32'h611d_1cd1;
    int                        value_errors = 0;
    int                        timeout_errors = 0;
    int                        cur_row = -1;

    opl3_mix_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_clk_en  (sample_clk_en),
        .op_out         (op_out),
        .cnt            (cnt),
        .connection_sel (connection_sel),
        .ryt            (ryt),
        .out_en         (out_en),
        .channel_a      (channel_a),
        .channel_b      (channel_b),
        .channel_c      (channel_c),
        .channel_d      (channel_d),
        .mix_done       (mix_done)
    );

    always #4 clk = ~clk;

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: row %0d %s got %0d, expected %0d",
                     $time, cur_row, name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("ERROR at %0t: row %0d mix_done after %0d edges, expected %0d",
                     $time, cur_row, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // channel value straight from the connection rules
    function automatic int chan_value(input op_word_t [NUM_OPS-1:0] o, input logic [17:0] cb,
                                      input logic [5:0] sb, input logic r, input int ch);
        int b;
        int c;
        int base;
        int m;
        logic [1:0] pr;
        b    = ch / 9;
        c    = ch % 9;
        base = b * 18;
        if (c < 3) begin
            m = c;
        end else if (c < 6) begin
            m = c + 3;
        end else begin
            m = c + 6;
        end
        if (b == 0 && r && c >= 6) begin
            if (c == 6) begin
                return cb[ch] ? int'(o[15]) : int'(o[12]);  // bass drum
            end
            return int'(o[m]) + int'(o[m + 3]);
        end
        if (c < 3 && sb[b * 3 + c]) begin
            pr = {cb[ch], cb[ch + 3]};
            case (pr)
                2'b00:   return int'(o[base + c + 9]);
                2'b01:   return int'(o[base + c + 3]) + int'(o[base + c + 9]);
                2'b10:   return int'(o[base + c]) + int'(o[base + c + 9]);
                default: return int'(o[base + c]) + int'(o[base + c + 6]) + int'(o[base + c + 9]);
            endcase
        end
        if (cb[ch]) begin
            return int'(o[base + m]) + int'(o[base + m + 3]);
        end
        return int'(o[base + m + 3]);  // FM, carrier only
    endfunction

    function automatic sample_t bus_expect(input row_t row, input op_word_t [NUM_OPS-1:0] o,
                                           input int k);
        int sum;
        sum = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (row.en[k][ch]) begin
                sum += chan_value(o, row.cnt, row.sel, row.ryt, ch);
            end
        end
        if (sum > 16383) begin
            return sample_t'(16383);
        end else if (sum < -16384) begin
            return sample_t'(-16384);
        end
        return sample_t'(sum);
    endfunction

    task automatic add_row(input logic [17:0] c, input logic [5:0] s, input logic r,
                           input logic [71:0] e, input logic [1:0] f, input op_word_t v,
                           input logic d, input logic x, input sample_t [3:0] ex);
        row_t row;
        row.cnt      = c;
        row.sel      = s;
        row.ryt      = r;
        row.en       = e;
        row.fill     = f;
        row.fill_val = v;
        row.directed = d;
        row.extra    = x;
        row.exp      = ex;
        table_q.push_back(row);
    endtask

    task automatic fill_ops(input logic [1:0] mode, input op_word_t value);
        for (int i = 0; i < NUM_OPS; i++) begin
            case (mode)
                FILL_RAND:  ops[i] = op_word_t'($random(seed));
                FILL_SMALL: ops[i] = op_word_t'($random(seed) % 512);
                default:    ops[i] = value;
            endcase
        end
    endtask

    // called on a falling edge, returns on the falling edge after mix_done
    task automatic run_row(input int idx);
        row_t    row;
        sample_t want [4];
        int      edges;
        row = table_q[idx];
        fill_ops(row.fill, row.fill_val);
        for (int k = 0; k < 4; k++) begin
            want[k] = row.directed ? row.exp[k] : bus_expect(row, ops, k);
        end
        cnt            = row.cnt;
        connection_sel = row.sel;
        ryt            = row.ryt;
        out_en         = row.en;
        op_out         = ops;
        sample_clk_en  = 1'b1;
        @(negedge clk);  // strobe taken at edge 0
        sample_clk_en = 1'b0;
        edges = 0;
        while (!mix_done && edges < WAIT_LIMIT) begin
            if (row.extra && edges == 5) begin
                sample_clk_en = 1'b1;  // must be ignored, and so must the new frame
                op_out        = ~ops;
                cnt           = ~row.cnt;
            end else begin
                sample_clk_en = 1'b0;
            end
            @(negedge clk);
            edges++;
        end
        if (!mix_done) begin
            timeout_errors++;
            $display("row %0d: mix_done never arrived within %0d cycles of the strobe",
                     idx, WAIT_LIMIT);
        end else begin
            check_latency(edges, LATENCY);
            check_sample("channel_a", channel_a, want[0]);
            check_sample("channel_b", channel_b, want[1]);
            check_sample("channel_c", channel_c, want[2]);
            check_sample("channel_d", channel_d, want[3]);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        sample_clk_en  = 1'b0;
        op_out         = '0;
        cnt            = '0;
        connection_sel = '0;
        ryt            = 1'b0;
        out_en         = '0;

        // carriers only, then bus selection
        add_row(18'h00000, 6'h00, 1'b0, EN_ALL, FILL_RAND, '0, 1'b0, 1'b0, '0);
        add_row(18'h00000, 6'h00, 1'b0, EN_ALL, FILL_SMALL, '0, 1'b0, 1'b0, '0);
        add_row(18'h2a5c3, 6'h00, 1'b0, 72'h0, FILL_RAND, '0, 1'b1, 1'b0, '0);
        add_row(18'h2a5c3, 6'h00, 1'b0, {18'h00080, 18'h20000, 18'h00400, 18'h00008},
                FILL_RAND, '0, 1'b0, 1'b0, '0);
        add_row(18'h00000, 6'h00, 1'b0, {18'h00000, 18'h3fe00, 18'h3ffff, 18'h00001},
                FILL_CONST, 13'sd100, 1'b1, 1'b0, {15'sd0, 15'sd900, 15'sd1800, 15'sd100});
        // 4-op pairs 00, 01, 10, 11 on channels 0-2 of both banks
        add_row(18'h381c0, 6'h3f, 1'b0, {18'h3ffff, 18'h381c0, 18'h07038, 18'h00e07},
                FILL_SMALL, '0, 1'b0, 1'b0, '0);
        add_row(18'h3f1f8, 6'h3f, 1'b0, {18'h3ffff, 18'h381c0, 18'h07038, 18'h00e07},
                FILL_SMALL, '0, 1'b0, 1'b0, '0);
        add_row(18'h38fc7, 6'h3f, 1'b0, {18'h3ffff, 18'h381c0, 18'h07038, 18'h00e07},
                FILL_SMALL, '0, 1'b0, 1'b0, '0);
        add_row(18'h3ffff, 6'h3f, 1'b0, {18'h3ffff, 18'h381c0, 18'h07038, 18'h00e07},
                FILL_SMALL, '0, 1'b0, 1'b0, '0);
        add_row(18'h2b6d9, 6'h2a, 1'b0, EN_ALL, FILL_SMALL, '0, 1'b0, 1'b0, '0);
        // rhythm, bass drum with cnt set and clear
        add_row(18'h00040, 6'h3f, 1'b1, {18'h3ffff, 18'h00040, 18'h38000, 18'h001c0},
                FILL_SMALL, '0, 1'b0, 1'b0, '0);
        add_row(18'h3fe3f, 6'h00, 1'b1, {18'h3ffff, 18'h00040, 18'h38000, 18'h001c0},
                FILL_SMALL, '0, 1'b0, 1'b0, '0);
        // saturation at both ends
        add_row(18'h3ffff, 6'h00, 1'b0, EN_ALL, FILL_CONST, 13'sd4095, 1'b1, 1'b0,
                {4{15'h3fff}});
        add_row(18'h3ffff, 6'h00, 1'b0, EN_ALL, FILL_CONST, 13'h1000, 1'b1, 1'b0,
                {4{15'h4000}});
        // strobe during a sweep, then a plain row behind it
        add_row(18'h15a5a, 6'h15, 1'b0, EN_ALL, FILL_SMALL, '0, 1'b0, 1'b1, '0);
        add_row(18'h0f0f0, 6'h21, 1'b0, EN_ALL, FILL_RAND, '0, 1'b0, 1'b0, '0);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("mix_done after reset", mix_done, 1'b0);
        check_sample("channel_a", channel_a, '0);
        check_sample("channel_b", channel_b, '0);
        check_sample("channel_c", channel_c, '0);
        check_sample("channel_d", channel_d, '0);

        for (int r = 0; r < table_q.size(); r++) begin
            cur_row = r;
            run_row(r);
        end

        $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
opl3_mix_pkg.sv
mix_seq_if.sv
op_capture.sv
mix_sequencer.sv
channel_connect.sv
output_mixer.sv
opl3_mix_top.sv
tb_opl3_mix.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module tb_opl3_mix -o tb_opl3_mix \
    > build.log 2>&1 \
    && ./obj_dir/tb_opl3_mix > sim.log 2>&1 \
    || echo "build or simulation did not complete, see build.log and sim.log"
grep -qF "*** PASSED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
